// ==== Bender.yml ====
package:
  name: axi4_lite_reg

sources:
  - hw/axi4_lite_pkg.sv
  - hw/reg_bank_pkg.sv
  - hw/axi4_stream_if.sv
  - hw/axi4_lite_bus_to_stream.sv
  - hw/reg_request_arbiter.sv
  - hw/reg_bank.sv
  - hw/axi4_lite_reg_top.sv
  - target: test
    files:
      - tests/axi4_lite_reg_tb.sv

// ==== flist.f ====
hw/axi4_lite_pkg.sv
hw/reg_bank_pkg.sv
hw/axi4_stream_if.sv
hw/axi4_lite_bus_to_stream.sv
hw/reg_request_arbiter.sv
hw/reg_bank.sv
hw/axi4_lite_reg_top.sv
tests/axi4_lite_reg_tb.sv

// ==== hw/axi4_lite_bus_to_stream.sv ====
/* AXI4-Lite slave front end.
 * Splits the bus into stream channels, with a skid buffer on each request channel.
 */
`timescale 1ns/1ps

module axi4_lite_bus_to_stream (
    input  logic aclk,
    input  logic rst_n,
    input  logic awvalid,
    output logic awready,
    input  logic [axi4_lite_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic [axi4_lite_pkg::PROT_WIDTH-1:0] awprot,
    input  logic wvalid,
    output logic wready,
    input  logic [axi4_lite_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [axi4_lite_pkg::STRB_WIDTH-1:0] wstrb,
    output logic bvalid,
    input  logic bready,
    output axi4_lite_pkg::response_t bresp,
    input  logic arvalid,
    output logic arready,
    input  logic [axi4_lite_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic [axi4_lite_pkg::PROT_WIDTH-1:0] arprot,
    output logic rvalid,
    input  logic rready,
    output logic [axi4_lite_pkg::DATA_WIDTH-1:0] rdata,
    output axi4_lite_pkg::response_t rresp,
    axi4_stream_if.tx write_address,
    axi4_stream_if.tx write_data,
    axi4_stream_if.tx read_address,
    axi4_stream_if.rx write_response,
    axi4_stream_if.rx read_data
);
    import axi4_lite_pkg::*;

    // One stream beat, wide enough for any request channel.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic [ADDR_WIDTH-1:0] dest;
        logic [PROT_WIDTH-1:0] user;
    } beat_t;

    // Channel 0 is AW, 1 is W, 2 is AR.
    logic  in_valid [REQ_CHANNELS];
    logic  in_ready [REQ_CHANNELS];
    beat_t in_beat [REQ_CHANNELS];
    logic  out_ready [REQ_CHANNELS];
    logic  main_valid [REQ_CHANNELS]; // Output stage of the skid buffer.
    beat_t main_beat [REQ_CHANNELS];
    logic  skid_valid [REQ_CHANNELS]; // Overflow entry, filled while the output stalls.
    beat_t skid_beat [REQ_CHANNELS];
    logic  push [REQ_CHANNELS];
    logic  pop [REQ_CHANNELS];

    always_comb begin
        in_valid[0] = awvalid;
        in_beat[0]  = '{data: '0, strb: '1, dest: awaddr, user: awprot};
        in_valid[1] = wvalid;
        in_beat[1]  = '{data: wdata, strb: wstrb, dest: '0, user: '0};
        in_valid[2] = arvalid;
        in_beat[2]  = '{data: '0, strb: '1, dest: araddr, user: arprot};
        out_ready[0] = write_address.tready;
        out_ready[1] = write_data.tready;
        out_ready[2] = read_address.tready;
        for (int i = 0; i < REQ_CHANNELS; i++) begin
            in_ready[i] = !skid_valid[i]; // Space while the skid entry is free.
            push[i] = in_valid[i] && in_ready[i];
            pop[i]  = main_valid[i] && out_ready[i];
        end
    end

    assign awready = in_ready[0];
    assign wready  = in_ready[1];
    assign arready = in_ready[2];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REQ_CHANNELS; i++) begin
                main_valid[i] <= 1'b0;
                skid_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < REQ_CHANNELS; i++) begin
                if (pop[i] || !main_valid[i])
                    main_valid[i] <= skid_valid[i] || push[i]; // Refill from skid first.
                if (push[i] && main_valid[i] && !pop[i])
                    skid_valid[i] <= 1'b1; // Output stalled, park the beat.
                else if (pop[i])
                    skid_valid[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < REQ_CHANNELS; i++) begin
            if (pop[i] || !main_valid[i])
                main_beat[i] <= skid_valid[i] ? skid_beat[i] : in_beat[i];
            if (!skid_valid[i])
                skid_beat[i] <= in_beat[i]; // Only kept when skid_valid is set.
        end
    end

    assign write_address.tvalid = main_valid[0];
    assign write_address.tdata  = main_beat[0].data;
    assign write_address.tstrb  = main_beat[0].strb;
    assign write_address.tdest  = main_beat[0].dest;
    assign write_address.tuser  = main_beat[0].user;
    assign write_data.tvalid    = main_valid[1];
    assign write_data.tdata     = main_beat[1].data;
    assign write_data.tstrb     = main_beat[1].strb;
    assign write_data.tdest     = main_beat[1].dest;
    assign write_data.tuser     = main_beat[1].user;
    assign read_address.tvalid  = main_valid[2];
    assign read_address.tdata   = main_beat[2].data;
    assign read_address.tstrb   = main_beat[2].strb;
    assign read_address.tdest   = main_beat[2].dest;
    assign read_address.tuser   = main_beat[2].user;

    // Responses pass straight through; the code sits in the low bits of tuser.
    assign bvalid = write_response.tvalid;
    assign bresp  = response_t'(write_response.tuser[$bits(response_t)-1:0]);
    assign write_response.tready = bready;
    assign rvalid = read_data.tvalid;
    assign rdata  = read_data.tdata;
    assign rresp  = response_t'(read_data.tuser[$bits(response_t)-1:0]);
    assign read_data.tready = rready;

    // A stalled write address must not change before it is taken.
    awaddr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> $stable(awaddr));

endmodule

// ==== hw/axi4_lite_pkg.sv ====
/* AXI4-Lite bus definitions.
 * Channel widths and the response encoding shared by the bus side of the design.
 */
package axi4_lite_pkg;

    // Byte address and data paths.
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8; // One strobe bit per byte.
    localparam int PROT_WIDTH = 3;

    // Low address bits that select a byte within a data word.
    localparam int ADDR_LSB = $clog2(STRB_WIDTH);

    // AW, W and AR are the request channels of the slave.
    localparam int REQ_CHANNELS = 3;

    // Response codes carried on BRESP and RRESP.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01, // Never produced, no exclusive access support.
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } response_t;

endpackage

// ==== hw/axi4_lite_reg_top.sv ====
/* AXI4-Lite register block top level.
 * Front end, request arbiter and register bank behind plain AXI4-Lite ports.
 */
`timescale 1ns/1ps

module axi4_lite_reg_top (
    input  logic aclk,
    input  logic rst_n,
    input  logic awvalid,
    output logic awready,
    input  logic [axi4_lite_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic [axi4_lite_pkg::PROT_WIDTH-1:0] awprot,
    input  logic wvalid,
    output logic wready,
    input  logic [axi4_lite_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [axi4_lite_pkg::STRB_WIDTH-1:0] wstrb,
    output logic bvalid,
    input  logic bready,
    output axi4_lite_pkg::response_t bresp,
    input  logic arvalid,
    output logic arready,
    input  logic [axi4_lite_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic [axi4_lite_pkg::PROT_WIDTH-1:0] arprot,
    output logic rvalid,
    input  logic rready,
    output logic [axi4_lite_pkg::DATA_WIDTH-1:0] rdata,
    output axi4_lite_pkg::response_t rresp
);

    axi4_stream_if write_address ();
    axi4_stream_if write_data ();
    axi4_stream_if read_address ();
    axi4_stream_if write_response ();
    axi4_stream_if read_data ();
    reg_req_if request ();

    // Bus side: skid-buffered requests out, responses back in.
    axi4_lite_bus_to_stream bus_to_stream_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .awprot(awprot),
        .wvalid(wvalid),
        .wready(wready),
        .wdata(wdata),
        .wstrb(wstrb),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .arprot(arprot),
        .rvalid(rvalid),
        .rready(rready),
        .rdata(rdata),
        .rresp(rresp),
        .write_address(write_address),
        .write_data(write_data),
        .read_address(read_address),
        .write_response(write_response),
        .read_data(read_data)
    );

    reg_request_arbiter arbiter_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .write_address(write_address),
        .write_data(write_data),
        .read_address(read_address),
        .request(request)
    );

    reg_bank bank_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .request(request),
        .write_response(write_response),
        .read_data(read_data)
    );

endmodule

// ==== hw/axi4_stream_if.sv ====
/* Stream channel and register request interfaces.
 * Carry the split AXI4-Lite channels and the arbiter-to-bank request.
 */
`timescale 1ns/1ps

interface axi4_stream_if;
    import axi4_lite_pkg::*;

    logic tvalid;
    logic tready;
    logic [DATA_WIDTH-1:0] tdata; // Write or read data.
    logic [STRB_WIDTH-1:0] tstrb; // Byte strobes.
    logic [ADDR_WIDTH-1:0] tdest; // Byte address.
    logic [PROT_WIDTH-1:0] tuser; // Protection or response code.

    modport tx (output tvalid, tdata, tstrb, tdest, tuser, input tready);
    modport rx (input tvalid, tdata, tstrb, tdest, tuser, output tready);
endinterface

interface reg_req_if;
    import axi4_lite_pkg::*;
    import reg_bank_pkg::*;

    logic valid;
    logic ready;
    reg_op_t op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata; // Don't care on reads.
    logic [STRB_WIDTH-1:0] strb;
    logic [PROT_WIDTH-1:0] prot;

    modport source (output valid, op, addr, wdata, strb, prot, input ready);
    modport sink (input valid, op, addr, wdata, strb, prot, output ready);
endinterface

// ==== hw/reg_bank.sv ====
/* Register bank.
 * Sixteen 32-bit registers with byte strobes, a protected upper half and address decode.
 */
`timescale 1ns/1ps

module reg_bank (
    input  logic aclk,
    input  logic rst_n,
    reg_req_if.sink request,
    axi4_stream_if.tx write_response,
    axi4_stream_if.tx read_data
);
    import axi4_lite_pkg::*;
    import reg_bank_pkg::*;

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    logic [REG_INDEX_WIDTH-1:0] index;
    logic in_range;
    logic refused;
    logic accept;
    logic write_ok;
    response_t resp;
    logic bvalid_q;
    logic rvalid_q;
    response_t bresp_q;
    response_t rresp_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    assign index    = request.addr[ADDR_LSB +: REG_INDEX_WIDTH]; // Word index.
    assign in_range = (request.addr >> ADDR_LSB) < REG_COUNT;
    // Upper half needs the privileged bit for writes; reads are always allowed.
    assign refused  = request.op == REG_WRITE && index >= REG_PROTECTED_BASE
                      && !request.prot[0];

    always_comb begin
        if (!in_range)
            resp = RESP_DECERR;
        else if (refused)
            resp = RESP_SLVERR;
        else
            resp = RESP_OKAY;
    end

    // Take a request only when its response slot is free or draining.
    assign request.ready = (request.op == REG_WRITE) ? (!bvalid_q || write_response.tready)
                                                     : (!rvalid_q || read_data.tready);
    assign accept   = request.valid && request.ready;
    assign write_ok = accept && request.op == REG_WRITE && resp == RESP_OKAY;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (write_ok) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (request.strb[b])
                    regs[index][8*b +: 8] <= request.wdata[8*b +: 8]; // Byte lane b.
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (accept && request.op == REG_WRITE)
                bvalid_q <= 1'b1;
            else if (write_response.tready)
                bvalid_q <= 1'b0;
            if (accept && request.op == REG_READ)
                rvalid_q <= 1'b1;
            else if (read_data.tready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && request.op == REG_WRITE)
            bresp_q <= resp;
        if (accept && request.op == REG_READ) begin
            rresp_q <= resp;
            rdata_q <= in_range ? regs[index] : '0; // Zero outside the bank.
        end
    end

    assign write_response.tvalid = bvalid_q;
    assign write_response.tuser  = PROT_WIDTH'(bresp_q);
    assign write_response.tdata  = '0;
    assign write_response.tstrb  = '0;
    assign write_response.tdest  = '0;
    assign read_data.tvalid = rvalid_q;
    assign read_data.tdata  = rdata_q;
    assign read_data.tuser  = PROT_WIDTH'(rresp_q);
    assign read_data.tstrb  = '1;
    assign read_data.tdest  = '0;

    // A read never produces a write response.
    no_b_from_read: assert property (@(posedge aclk) disable iff (!rst_n)
        accept && request.op == REG_READ |=> !$rose(write_response.tvalid));

endmodule

// ==== hw/reg_bank_pkg.sv ====
/* Register bank definitions.
 * Bank size, index width, protected region and request opcodes.
 */
package reg_bank_pkg;

    // Sixteen 32-bit registers.
    localparam int REG_COUNT = 16;
    localparam int REG_INDEX_WIDTH = $clog2(REG_COUNT);

    // Registers from this index upward are writable only with privileged prot.
    localparam int REG_PROTECTED_BASE = 8;

    // Request kind handed from the arbiter to the bank.
    typedef enum logic {
        REG_WRITE = 1'b0,
        REG_READ  = 1'b1
    } reg_op_t;

endpackage

// ==== hw/reg_request_arbiter.sv ====
/* Register request arbiter.
 * Joins write address with write data and alternates writes and reads into one request.
 */
`timescale 1ns/1ps

module reg_request_arbiter (
    input  logic aclk,
    input  logic rst_n,
    axi4_stream_if.rx write_address,
    axi4_stream_if.rx write_data,
    axi4_stream_if.rx read_address,
    reg_req_if.source request
);
    import axi4_lite_pkg::*;
    import reg_bank_pkg::*;

    // Kind that wins the next conflict.
    typedef enum logic {
        GRANT_WRITE,
        GRANT_READ
    } grant_t;

    grant_t priority_q;
    logic write_pending;
    logic read_pending;
    logic load;
    logic write_wins;
    logic grant_write;
    logic grant_read;
    logic valid_q;
    reg_op_t op_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [STRB_WIDTH-1:0] strb_q;
    logic [PROT_WIDTH-1:0] prot_q;

    assign write_pending = write_address.tvalid && write_data.tvalid; // Both halves needed.
    assign read_pending  = read_address.tvalid;
    assign load = !valid_q || request.ready; // Output register free or emptying.

    assign write_wins  = write_pending && (!read_pending || priority_q == GRANT_WRITE);
    assign grant_write = load && write_wins;
    assign grant_read  = load && read_pending && !write_wins;

    // Address and data of a write are taken in the same cycle.
    assign write_address.tready = grant_write;
    assign write_data.tready    = grant_write;
    assign read_address.tready  = grant_read;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            priority_q <= GRANT_WRITE;
        end else begin
            if (load)
                valid_q <= grant_write || grant_read;
            if (grant_write)
                priority_q <= GRANT_READ; // Loser goes first next time.
            else if (grant_read)
                priority_q <= GRANT_WRITE;
        end
    end

    always_ff @(posedge aclk) begin
        if (grant_write) begin
            op_q    <= REG_WRITE;
            addr_q  <= write_address.tdest;
            prot_q  <= write_address.tuser;
            wdata_q <= write_data.tdata;
            strb_q  <= write_data.tstrb;
        end else if (grant_read) begin
            op_q    <= REG_READ;
            addr_q  <= read_address.tdest;
            prot_q  <= read_address.tuser;
            wdata_q <= '0;
            strb_q  <= '0; // Reads touch no byte.
        end
    end

    assign request.valid = valid_q;
    assign request.op    = op_q;
    assign request.addr  = addr_q;
    assign request.wdata = wdata_q;
    assign request.strb  = strb_q;
    assign request.prot  = prot_q;

    // An offered request is held until the bank takes it.
    request_held: assert property (@(posedge aclk) disable iff (!rst_n)
        request.valid && !request.ready |=> request.valid);

endmodule

// ==== tests/axi4_lite_reg_tb.sv ====
/* AXI4-Lite register block testbench.
 * Applies a stimulus table on the bus ports and checks responses against a register model.
 */
`timescale 1ns/1ps

module axi4_lite_reg_tb;
    import axi4_lite_pkg::*;
    import reg_bank_pkg::*;

    // One bus access from the stimulus table.
    typedef struct packed {
        reg_op_t op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [PROT_WIDTH-1:0] prot;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } entry_t;

    logic aclk;
    logic rst_n;
    logic awvalid, awready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [PROT_WIDTH-1:0] awprot;
    logic wvalid, wready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic bvalid, bready;
    response_t bresp;
    logic arvalid, arready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [PROT_WIDTH-1:0] arprot;
    logic rvalid, rready;
    logic [DATA_WIDTH-1:0] rdata;
    response_t rresp;

    entry_t stim [$];
    int unsigned conc_start; // First entry of the overlapped phase.
    int unsigned conc_end; // First entry after the overlapped phase.
    logic [DATA_WIDTH-1:0] model_regs [REG_COUNT];
    response_t exp_bresp [$];
    response_t exp_rresp [$];
    logic [DATA_WIDTH-1:0] exp_rdata [$];
    int unsigned cycle_limit = 0;
    int unsigned cycles = 0;
    int unsigned checks = 0;
    int unsigned mismatches = 0;
    int unsigned other_errors = 0;
    int unsigned writes_sent = 0;
    int unsigned reads_sent = 0;
    int unsigned b_seen = 0;
    int unsigned r_seen = 0;

    axi4_lite_reg_top axi4_lite_reg_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk; // 40 ns period.
    end

    // Random response back-pressure, changed on the falling edge.
    initial begin
        bready = 1'b1;
        rready = 1'b1;
        forever begin
            @(negedge aclk);
            bready = ($urandom % 4) != 0; // High about three cycles in four.
            rready = ($urandom % 4) != 0;
        end
    end

    // Bank rules: decode first, then the write protection of the upper half.
    function automatic response_t expected_resp(reg_op_t op, logic [ADDR_WIDTH-1:0] addr,
                                               logic [PROT_WIDTH-1:0] prot);
        logic [ADDR_WIDTH-1:0] word;
        word = addr >> 2; // Four bytes per register.
        if (word >= REG_COUNT)
            return RESP_DECERR;
        if (op == REG_WRITE && word >= REG_PROTECTED_BASE && !prot[0])
            return RESP_SLVERR;
        return RESP_OKAY;
    endfunction

    task automatic add(input reg_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                       input logic [PROT_WIDTH-1:0] prot, input logic [DATA_WIDTH-1:0] data,
                       input logic [STRB_WIDTH-1:0] strb);
        entry_t e;
        e = '{op: op, addr: addr, prot: prot, data: data, strb: strb};
        stim.push_back(e);
    endtask

    task automatic build_table();
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        for (int i = 0; i < REG_COUNT; i++)
            add(REG_READ, 4 * i, 3'b000, '0, '0); // Every register reads zero after reset.
        data = $urandom;
        add(REG_WRITE, 32'h04, 3'b000, data, 4'hf);
        add(REG_READ, 32'h04, 3'b000, '0, '0);
        add(REG_WRITE, 32'h1c, 3'b000, 32'hcafe_f00d, 4'hf);
        add(REG_READ, 32'h1c, 3'b000, '0, '0);
        // Partial strobes on register 2.
        add(REG_WRITE, 32'h08, 3'b000, 32'h1122_3344, 4'hf);
        add(REG_WRITE, 32'h08, 3'b000, 32'haabb_ccdd, 4'b0101);
        add(REG_READ, 32'h08, 3'b000, '0, '0);
        data = $urandom;
        add(REG_WRITE, 32'h0a, 3'b000, data, 4'b1000); // Byte offset ignored.
        add(REG_READ, 32'h08, 3'b000, '0, '0);
        // Protected upper half.
        add(REG_WRITE, 32'h24, 3'b000, 32'hdead_beef, 4'hf);
        add(REG_READ, 32'h24, 3'b000, '0, '0);
        add(REG_WRITE, 32'h24, 3'b001, 32'hdead_beef, 4'hf);
        add(REG_READ, 32'h24, 3'b000, '0, '0);
        add(REG_WRITE, 32'h3c, 3'b110, 32'h5555_aaaa, 4'hf); // Bit 0 low, refused.
        add(REG_READ, 32'h3c, 3'b000, '0, '0);
        add(REG_WRITE, 32'h20, 3'b001, 32'h0bad_cafe, 4'hf);
        add(REG_WRITE, 32'h20, 3'b000, 32'hffff_ffff, 4'b0011);
        add(REG_READ, 32'h20, 3'b000, '0, '0);
        // Outside the bank.
        add(REG_READ, 32'h40, 3'b001, '0, '0);
        add(REG_WRITE, 32'h40, 3'b001, 32'h1234_5678, 4'hf);
        add(REG_READ, 32'h100, 3'b000, '0, '0);
        add(REG_WRITE, 32'hffff_fffc, 3'b001, 32'h8765_4321, 4'hf);
        add(REG_READ, 32'h8000_0000, 3'b000, '0, '0);
        // Registers 0 and 15 share low address bits with the refused writes.
        add(REG_READ, 32'h00, 3'b000, '0, '0);
        add(REG_READ, 32'h3c, 3'b000, '0, '0);
        // Overlapped phase: writes to registers 0..3, reads of 4..11.
        conc_start = stim.size();
        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            strb = STRB_WIDTH'($urandom);
            add(REG_WRITE, 4 * (i % 4), 3'b001, data, strb);
            add(REG_READ, 32'h10 + 4 * i, 3'(i), '0, '0);
        end
        conc_end = stim.size();
        // Readback of what the overlapped writes left behind.
        for (int i = 0; i < 4; i++)
            add(REG_READ, 4 * i, 3'b000, '0, '0);
    endtask

    task automatic send_write(input entry_t e);
        response_t resp;
        logic aw_done;
        logic w_done;
        resp = expected_resp(e.op, e.addr, e.prot);
        if (resp == RESP_OKAY) begin
            for (int b = 0; b < STRB_WIDTH; b++)
                if (e.strb[b])
                    model_regs[e.addr[5:2]][8*b +: 8] = e.data[8*b +: 8];
        end
        exp_bresp.push_back(resp);
        writes_sent++;
        @(negedge aclk);
        awvalid = 1'b1;
        awaddr = e.addr;
        awprot = e.prot;
        wvalid = 1'b1;
        wdata = e.data;
        wstrb = e.strb;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done)) begin
            @(posedge aclk);
            aw_done = aw_done || (awvalid && awready); // The channels may finish apart.
            w_done = w_done || (wvalid && wready);
            @(negedge aclk);
            if (aw_done)
                awvalid = 1'b0;
            if (w_done)
                wvalid = 1'b0;
        end
    endtask

    task automatic send_read(input entry_t e);
        response_t resp;
        resp = expected_resp(e.op, e.addr, e.prot);
        exp_rresp.push_back(resp);
        exp_rdata.push_back(resp == RESP_DECERR ? '0 : model_regs[e.addr[5:2]]);
        reads_sent++;
        @(negedge aclk);
        arvalid = 1'b1;
        araddr = e.addr;
        arprot = e.prot;
        do
            @(posedge aclk);
        while (!arready);
        @(negedge aclk);
        arvalid = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        if (e.op == REG_WRITE)
            send_write(e);
        else
            send_read(e);
    endtask

    task automatic issue_writes();
        for (int i = conc_start; i < conc_end; i++)
            if (stim[i].op == REG_WRITE)
                send_write(stim[i]);
    endtask

    task automatic issue_reads();
        for (int i = conc_start; i < conc_end; i++)
            if (stim[i].op == REG_READ)
                send_read(stim[i]);
    endtask

    // Until every issued access has been answered.
    task automatic wait_idle();
        while (exp_bresp.size() != 0 || exp_rresp.size() != 0)
            @(negedge aclk);
    endtask

    task automatic check_write_response();
        response_t want;
        b_seen++;
        assert (exp_bresp.size() != 0) else begin
            other_errors++;
            $display("A write response arrived at %0t with no write outstanding", $time);
        end
        if (exp_bresp.size() != 0) begin
            want = exp_bresp.pop_front();
            checks++;
            assert (bresp == want) else begin
                mismatches++;
                $display("Error at %0t: bresp is %s, expected %s", $time, bresp.name(),
                         want.name());
            end
        end
    endtask

    task automatic check_read_data();
        response_t want;
        logic [DATA_WIDTH-1:0] want_data;
        r_seen++;
        assert (exp_rresp.size() != 0) else begin
            other_errors++;
            $display("Read data arrived at %0t with no read outstanding", $time);
        end
        if (exp_rresp.size() != 0) begin
            want = exp_rresp.pop_front();
            want_data = exp_rdata.pop_front();
            checks += 2;
            assert (rresp == want) else begin
                mismatches++;
                $display("Error at %0t: rresp is %s, expected %s", $time, rresp.name(),
                         want.name());
            end
            assert (rdata == want_data) else begin
                mismatches++;
                $display("Error at %0t: rdata is %h, expected %h", $time, rdata, want_data);
            end
        end
    endtask

    // Response monitor, one check per completed transfer.
    initial begin
        forever begin
            @(posedge aclk);
            if (rst_n && bvalid && bready)
                check_write_response();
            if (rst_n && rvalid && rready)
                check_read_data();
        end
    end

    task automatic report_and_finish();
        $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
                 other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // Watchdog sized from the table length.
    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge aclk);
            cycles++;
        end
        other_errors++;
        $display("The run timed out after %0d cycles", cycles);
        report_and_finish();
    end

    initial begin
        void'($urandom(29));
        rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        awprot = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        arvalid = 1'b0;
        araddr = '0;
        arprot = '0;
        for (int i = 0; i < REG_COUNT; i++)
            model_regs[i] = '0;
        build_table();
        cycle_limit = stim.size() * 20 + 100;
        repeat (16) @(negedge aclk);
        checks++;
        assert (!bvalid && !rvalid && awready && wready && arready) else begin
            other_errors++;
            $display("Handshake outputs are not at their reset values at %0t", $time);
        end
        rst_n = 1'b1;
        for (int i = 0; i < conc_start; i++) begin
            apply_entry(stim[i]); // One access at a time.
            wait_idle();
        end
        fork
            issue_writes();
            issue_reads();
        join
        wait_idle();
        for (int i = conc_end; i < stim.size(); i++) begin
            apply_entry(stim[i]);
            wait_idle();
        end
        checks++;
        assert (b_seen == writes_sent && r_seen == reads_sent) else begin
            other_errors++;
            $display("Responses do not match the issued accesses one for one");
        end
        report_and_finish();
    end

endmodule
